/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // queue and FIFO sizing
    localparam int IQ_DEPTH          = 8;
    localparam int RID_FIFO_DEPTH    = 8;   // outstanding memory requests
    localparam int COMMIT_FIFO_DEPTH = 2;
    localparam int CDB_PORTS         = 2;
    localparam int DISPATCH_WIDTH    = 2;

    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

    localparam int ROB_ID_W   = 6;
    localparam int WORD_W     = 32;
    localparam int ADDR_IMM_W = 28;

    // operand slots inside dispatch_t
    localparam int OPND_DATA = 0;
    localparam int OPND_BASE = 1;

    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [WORD_W-1:0]   word_t;

    typedef enum logic [1:0] {
        MSIZE_BYTE = 2'd0,
        MSIZE_HALF = 2'd1,
        MSIZE_WORD = 2'd3
    } mem_size_e;

    // one source operand as dispatch hands it over
    typedef struct packed {
        logic    valid;
        rob_id_t tag;     // producer rob id while not valid
        word_t   value;
    } operand_t;

    typedef struct packed {
        logic                  mem_write;
        mem_size_e             msize;
        logic [ADDR_IMM_W-1:0] addr_imm;
        word_t                 pc;
        rob_id_t               wreg;
    } lsu_static_t;

    typedef struct packed {
        lsu_static_t    info;
        operand_t [1:0] opnd;  // [0] store data, [1] base
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t wid;
        word_t   wdata;
        word_t   target_addr;  // access address for lsu results
    } cdb_t;

    typedef struct packed {
        word_t      vaddr;
        mem_size_e  msize;
        logic [3:0] strb;
        logic       write;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        word_t vaddr;
    } mem_resp_t;

endpackage

/* rtl/lsu_iq_entry.sv */
module lsu_iq_entry (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   flush_i,
    input  logic                                   alloc_i,
    input  lsu_pkg::dispatch_t                     alloc_data_i,
    input  logic                                   release_i,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0] cdb_i,
    output logic                                   busy_o,
    output logic                                   ready_o,
    output lsu_pkg::lsu_static_t                   static_o,
    output lsu_pkg::word_t [1:0]                   data_o
);

    logic                    busy_q;
    logic [1:0]              opnd_valid_q;
    lsu_pkg::rob_id_t [1:0]  opnd_tag_q;
    lsu_pkg::word_t [1:0]    opnd_value_q;
    lsu_pkg::lsu_static_t    static_q;
    lsu_pkg::operand_t [1:0] opnd_src;  // operand before snooping
    lsu_pkg::operand_t [1:0] opnd_d;

    // snoop both cdb ports, also on the allocating cycle
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (alloc_i) begin
                opnd_src[k] = alloc_data_i.opnd[k];
            end else begin
                opnd_src[k].valid = opnd_valid_q[k];
                opnd_src[k].tag   = opnd_tag_q[k];
                opnd_src[k].value = opnd_value_q[k];
            end
            opnd_d[k] = opnd_src[k];
            for (int p = 0; p < lsu_pkg::CDB_PORTS; p++) begin
                if (!opnd_src[k].valid && cdb_i[p].valid &&
                    cdb_i[p].wid == opnd_src[k].tag) begin
                    opnd_d[k].valid = 1'b1;
                    opnd_d[k].value = cdb_i[p].wdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q       <= 1'b0;
            opnd_valid_q <= '0;
        end else begin
            if (alloc_i) begin
                busy_q <= 1'b1;
            end else if (release_i) begin
                busy_q <= 1'b0;
            end
            opnd_valid_q <= {opnd_d[1].valid, opnd_d[0].valid};
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            static_q <= alloc_data_i.info;
        end
        for (int k = 0; k < 2; k++) begin
            opnd_tag_q[k]   <= opnd_d[k].tag;
            opnd_value_q[k] <= opnd_d[k].value;
        end
    end

    assign busy_o   = busy_q;
    assign ready_o  = busy_q && (&opnd_valid_q);  // both operands known
    assign static_o = static_q;
    assign data_o   = opnd_value_q;

endmodule

/* rtl/lsu_sync_fifo.sv */
module lsu_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4   // power of two, at least 2
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             flush_i,
    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic [WIDTH-1:0] push_data_i,
    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output logic [WIDTH-1:0] pop_data_o
);

    logic [WIDTH-1:0]           mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic [$clog2(DEPTH+1)-1:0] count_full;
    logic                       push;
    logic                       pop;

    assign count_full   = ($clog2(DEPTH + 1))'(DEPTH);
    assign push_ready_o = count_q != count_full;
    assign pop_valid_o  = count_q != '0;
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;
    assign pop_data_o   = mem_q[rd_ptr_q];  // read from the registered array

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

/* rtl/lsu_req_format.sv */
module lsu_req_format (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  lsu_pkg::lsu_static_t in_static_i,
    input  lsu_pkg::word_t [1:0] in_data_i,
    output logic                 req_valid_o,
    input  logic                 req_ready_i,
    output lsu_pkg::mem_req_t    req_o,
    output lsu_pkg::rob_id_t     issued_id_o
);

    logic                 valid_q;
    lsu_pkg::lsu_static_t static_q;
    lsu_pkg::word_t [1:0] data_q;
    lsu_pkg::word_t       vaddr;
    lsu_pkg::word_t       store_data;

    // takes a new entry when empty or emptying this cycle
    assign in_ready_o = !valid_q || req_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            static_q <= in_static_i;
            data_q   <= in_data_i;
        end
    end

    assign vaddr = {{(lsu_pkg::WORD_W - lsu_pkg::ADDR_IMM_W){
                        static_q.addr_imm[lsu_pkg::ADDR_IMM_W-1]}},
                    static_q.addr_imm} + data_q[lsu_pkg::OPND_BASE];
    assign store_data = data_q[lsu_pkg::OPND_DATA];

    always_comb begin
        req_o.vaddr = vaddr;
        req_o.msize = static_q.msize;
        req_o.write = static_q.mem_write;
        req_o.strb  = 4'b0000;       // loads carry no strobe
        req_o.wdata = store_data;
        case (static_q.msize)
            lsu_pkg::MSIZE_HALF: begin
                req_o.wdata = store_data << {vaddr[1], 4'd0};
                if (static_q.mem_write) begin
                    req_o.strb = 4'b0011 << {vaddr[1], 1'b0};
                end
            end
            lsu_pkg::MSIZE_BYTE: begin
                req_o.wdata = store_data << {vaddr[1:0], 3'd0};
                if (static_q.mem_write) begin
                    req_o.strb = 4'b0001 << vaddr[1:0];
                end
            end
            default: begin
                if (static_q.mem_write) begin
                    req_o.strb = 4'b1111;
                end
            end
        endcase
    end

    assign req_valid_o = valid_q;
    assign issued_id_o = static_q.wreg;

endmodule

/* rtl/lsu_issue_queue.sv */
module lsu_issue_queue (
    input  logic                                             clk,
    input  logic                                             rst_i,
    input  logic                                             flush_i,
    input  lsu_pkg::dispatch_t [lsu_pkg::DISPATCH_WIDTH-1:0] disp_i,
    input  logic [lsu_pkg::DISPATCH_WIDTH-1:0]               disp_valid_i,
    output logic                                             disp_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0]           cdb_i,
    output logic                                             head_valid_o,
    input  logic                                             head_ready_i,
    output lsu_pkg::lsu_static_t                             head_static_o,
    output lsu_pkg::word_t [1:0]                             head_data_o
);

    logic [lsu_pkg::IQ_PTR_W-1:0] head_q;
    logic [lsu_pkg::IQ_PTR_W-1:0] head_d;
    logic [lsu_pkg::IQ_PTR_W-1:0] tail_q;
    logic [lsu_pkg::IQ_PTR_W-1:0] tail_d;
    logic [lsu_pkg::IQ_PTR_W-1:0] tail_p1;
    logic [lsu_pkg::IQ_PTR_W-1:0] slot1_ptr;
    logic [lsu_pkg::IQ_CNT_W-1:0] count_q;
    logic [lsu_pkg::IQ_CNT_W-1:0] count_d;

    logic [lsu_pkg::DISPATCH_WIDTH-1:0] acc;   // accepted dispatch slots
    logic                               head_fire;

    logic [lsu_pkg::IQ_DEPTH-1:0]                entry_alloc;
    logic [lsu_pkg::IQ_DEPTH-1:0]                entry_take0;
    logic [lsu_pkg::IQ_DEPTH-1:0]                entry_release;
    logic [lsu_pkg::IQ_DEPTH-1:0]                entry_busy;
    logic [lsu_pkg::IQ_DEPTH-1:0]                entry_ready;
    lsu_pkg::dispatch_t [lsu_pkg::IQ_DEPTH-1:0]   entry_alloc_data;
    lsu_pkg::lsu_static_t [lsu_pkg::IQ_DEPTH-1:0] entry_static;
    lsu_pkg::word_t [lsu_pkg::IQ_DEPTH-1:0][1:0]  entry_data;

    assign acc = disp_valid_i & {lsu_pkg::DISPATCH_WIDTH{disp_ready_o}};

    // slot 1 goes behind slot 0 only when slot 0 is taken
    assign tail_p1   = tail_q + 1'b1;
    assign slot1_ptr = acc[0] ? tail_p1 : tail_q;

    // strict in-order issue from the head entry
    assign head_valid_o  = entry_busy[head_q] && entry_ready[head_q];
    assign head_fire     = head_valid_o && head_ready_i;
    assign head_static_o = entry_static[head_q];
    assign head_data_o   = entry_data[head_q];

    always_comb begin
        tail_d  = tail_q;
        count_d = count_q;
        if (acc[0]) begin
            tail_d  = tail_d + 1'b1;
            count_d = count_d + 1'b1;
        end
        if (acc[1]) begin
            tail_d  = tail_d + 1'b1;
            count_d = count_d + 1'b1;
        end
        if (head_fire) begin
            count_d = count_d - 1'b1;
        end
        head_d = head_fire ? head_q + 1'b1 : head_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            disp_ready_o <= 1'b1;
        end else begin
            head_q  <= head_d;
            tail_q  <= tail_d;
            count_q <= count_d;
            // room for two more after this edge
            disp_ready_o <= int'(count_d) <= lsu_pkg::IQ_DEPTH - 2;
        end
    end

    for (genvar i = 0; i < lsu_pkg::IQ_DEPTH; i++) begin : g_entry
        always_comb begin
            entry_take0[i]   = acc[0] && int'(tail_q) == i;
            entry_alloc[i]   = entry_take0[i] || (acc[1] && int'(slot1_ptr) == i);
            entry_release[i] = head_fire && int'(head_q) == i;
            entry_alloc_data[i] = entry_take0[i] ? disp_i[0] : disp_i[1];
        end

        lsu_iq_entry u_entry (
            .clk          (clk),
            .rst_i        (rst_i),
            .flush_i      (flush_i),
            .alloc_i      (entry_alloc[i]),
            .alloc_data_i (entry_alloc_data[i]),
            .release_i    (entry_release[i]),
            .cdb_i        (cdb_i),
            .busy_o       (entry_busy[i]),
            .ready_o      (entry_ready[i]),
            .static_o     (entry_static[i]),
            .data_o       (entry_data[i])
        );
    end

endmodule

/* rtl/lsu_issue_unit.sv */
module lsu_issue_unit (
    input  logic                                             clk,
    input  logic                                             rst_i,
    input  logic                                             flush_i,
    input  lsu_pkg::dispatch_t [lsu_pkg::DISPATCH_WIDTH-1:0] disp_i,
    input  logic [lsu_pkg::DISPATCH_WIDTH-1:0]               disp_valid_i,
    output logic                                             disp_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_PORTS-1:0]           cdb_i,
    output lsu_pkg::cdb_t                                    cdb_o,
    input  logic                                             cdb_ready_i,
    output logic                                             mem_req_valid_o,
    input  logic                                             mem_req_ready_i,
    output lsu_pkg::mem_req_t                                mem_req_o,
    input  logic                                             mem_resp_valid_i,
    output logic                                             mem_resp_ready_o,
    input  lsu_pkg::mem_resp_t                               mem_resp_i
);

    logic                 head_valid;
    logic                 head_ready;
    lsu_pkg::lsu_static_t head_static;
    lsu_pkg::word_t [1:0] head_data;

    logic             fmt_req_valid;
    logic             fmt_req_ready;
    lsu_pkg::rob_id_t issued_id;

    logic             rid_push_ready;
    logic             rid_pop_valid;
    lsu_pkg::rob_id_t rid_pop_data;
    logic             req_fire;
    logic             resp_fire;

    lsu_pkg::cdb_t commit_in;
    lsu_pkg::cdb_t commit_out;
    logic          commit_push_valid;
    logic          commit_pop_valid;

    lsu_issue_queue u_issue_queue (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .disp_i        (disp_i),
        .disp_valid_i  (disp_valid_i),
        .disp_ready_o  (disp_ready_o),
        .cdb_i         (cdb_i),
        .head_valid_o  (head_valid),
        .head_ready_i  (head_ready),
        .head_static_o (head_static),
        .head_data_o   (head_data)
    );

    lsu_req_format u_req_format (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .in_valid_i  (head_valid),
        .in_ready_o  (head_ready),
        .in_static_i (head_static),
        .in_data_i   (head_data),
        .req_valid_o (fmt_req_valid),
        .req_ready_i (fmt_req_ready),
        .req_o       (mem_req_o),
        .issued_id_o (issued_id)
    );

    // a request only leaves when its rob id has a slot
    assign fmt_req_ready   = mem_req_ready_i && rid_push_ready;
    assign mem_req_valid_o = fmt_req_valid && rid_push_ready;
    assign req_fire        = mem_req_valid_o && mem_req_ready_i;

    lsu_sync_fifo #(
        .WIDTH ($bits(lsu_pkg::rob_id_t)),
        .DEPTH (lsu_pkg::RID_FIFO_DEPTH)
    ) u_rid_fifo (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .push_valid_i (req_fire),
        .push_ready_o (rid_push_ready),
        .push_data_i  (issued_id),
        .pop_valid_o  (rid_pop_valid),
        .pop_ready_i  (resp_fire),
        .pop_data_o   (rid_pop_data)
    );

    // responses come back in order, so the oldest id belongs to them
    assign resp_fire         = mem_resp_valid_i && mem_resp_ready_o;
    assign commit_push_valid = mem_resp_valid_i && rid_pop_valid;  // no id, no result

    always_comb begin
        commit_in.valid       = 1'b1;
        commit_in.wid         = rid_pop_data;
        commit_in.wdata       = mem_resp_i.rdata;
        commit_in.target_addr = mem_resp_i.vaddr;
    end

    lsu_sync_fifo #(
        .WIDTH ($bits(lsu_pkg::cdb_t)),
        .DEPTH (lsu_pkg::COMMIT_FIFO_DEPTH)
    ) u_commit_fifo (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .push_valid_i (commit_push_valid),
        .push_ready_o (mem_resp_ready_o),
        .push_data_i  (commit_in),
        .pop_valid_o  (commit_pop_valid),
        .pop_ready_i  (cdb_ready_i),
        .pop_data_o   (commit_out)
    );

    always_comb begin
        cdb_o       = commit_out;
        cdb_o.valid = commit_pop_valid;
    end

endmodule

/* verification/lsu_issue_unit_assertions.sv */
module lsu_issue_unit_assertions (
    input logic              clk,
    input logic              rst_i,
    input logic              flush_i,
    input logic [1:0]        disp_valid_i,
    input logic              disp_ready_i,   // dut disp_ready_o
    input logic              issue_valid_i,  // queue head offered to the stage register
    input logic              issue_ready_i,
    input logic              req_valid_i,
    input logic              req_ready_i,
    input lsu_pkg::mem_req_t req_i,
    input lsu_pkg::cdb_t     cdb_out_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [lsu_pkg::IQ_CNT_W-1:0] occ_q;     // shadow count of queue entries
    logic [1:0]                   disp_acc;
    int                           failures = 0;  // failed assertion count

    assign disp_acc = disp_valid_i & {2{disp_ready_i}};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + disp_acc[0] + disp_acc[1] - (issue_valid_i && issue_ready_i);
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else begin
            failures++;
            $error("memory request dropped or changed while waiting for ready");
        end

    cdb_quiet_after_flush: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> !cdb_out_i.valid)
        else begin
            failures++;
            $error("result on cdb_o in the cycle after a flush");
        end

    disp_ready_room: assert property (@(posedge clk) disable iff (rst_i)
        (occ_q < lsu_pkg::IQ_DEPTH - 2) |-> disp_ready_i)
        else begin
            failures++;
            $error("disp_ready_o low although the queue has room for two");
        end

endmodule

bind lsu_issue_unit lsu_issue_unit_assertions u_assertions (
    .clk           (clk),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .disp_valid_i  (disp_valid_i),
    .disp_ready_i  (disp_ready_o),
    .issue_valid_i (head_valid),
    .issue_ready_i (head_ready),
    .req_valid_i   (mem_req_valid_o),
    .req_ready_i   (mem_req_ready_i),
    .req_i         (mem_req_o),
    .cdb_out_i     (cdb_o)
);

/* verification/tb_lsu_issue_unit.sv */
module tb_lsu_issue_unit;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic               write;
        lsu_pkg::mem_size_e size;
        logic [27:0]        imm;
        lsu_pkg::word_t     base;
        lsu_pkg::word_t     data;
        lsu_pkg::rob_id_t   rid;
        logic               pend;      // base waits for a cdb broadcast
        logic [3:0]         exp_strb;
    } stim_row_t;

    localparam int NUM_ROWS = 14;
    localparam stim_row_t ROWS [NUM_ROWS] = '{
        '{1'b1, lsu_pkg::MSIZE_WORD, 28'h0000010, 32'h1000_0000, 32'h1122_3344, 6'd1, 1'b0, 4'b1111},
        '{1'b1, lsu_pkg::MSIZE_HALF, 28'h0000002, 32'h1000_0000, 32'haaaa_beef, 6'd2, 1'b0, 4'b1100},
        '{1'b1, lsu_pkg::MSIZE_HALF, 28'h0000000, 32'h1000_0004, 32'h0000_1234, 6'd3, 1'b0, 4'b0011},
        '{1'b1, lsu_pkg::MSIZE_BYTE, 28'h0000001, 32'h1000_0000, 32'h0000_00a5, 6'd4, 1'b0, 4'b0010},
        '{1'b1, lsu_pkg::MSIZE_BYTE, 28'h0000002, 32'h1000_0000, 32'h0000_003c, 6'd5, 1'b0, 4'b0100},
        '{1'b1, lsu_pkg::MSIZE_BYTE, 28'hffffffb, 32'h1000_0008, 32'h0000_0077, 6'd6, 1'b0, 4'b1000},
        '{1'b1, lsu_pkg::MSIZE_BYTE, 28'h0000000, 32'h2000_0000, 32'h0000_0011, 6'd7, 1'b0, 4'b0001},
        '{1'b0, lsu_pkg::MSIZE_WORD, 28'hffffffc, 32'h3000_0010, 32'hdead_0001, 6'd8, 1'b0, 4'b0000},
        '{1'b0, lsu_pkg::MSIZE_HALF, 28'h0000006, 32'h3000_0000, 32'hdead_0002, 6'd9, 1'b0, 4'b0000},
        '{1'b0, lsu_pkg::MSIZE_BYTE, 28'h0000003, 32'h3000_0000, 32'hdead_0003, 6'd10, 1'b0, 4'b0000},
        '{1'b1, lsu_pkg::MSIZE_HALF, 28'h0000003, 32'h1000_0000, 32'h0000_5678, 6'd11, 1'b0, 4'b1100},
        '{1'b0, lsu_pkg::MSIZE_WORD, 28'h0000100, 32'h4000_0000, 32'h0000_0000, 6'd12, 1'b1, 4'b0000},
        '{1'b1, lsu_pkg::MSIZE_BYTE, 28'h0000005, 32'h4000_0000, 32'h0000_00c3, 6'd13, 1'b1, 4'b0010},
        '{1'b0, lsu_pkg::MSIZE_HALF, 28'h0000000, 32'h5000_0002, 32'h0000_0000, 6'd14, 1'b0, 4'b0000}
    };

    logic                     clk;
    logic                     rst_i;
    logic                     flush_i;
    lsu_pkg::dispatch_t [1:0] disp_i;
    logic [1:0]               disp_valid_i;
    logic                     disp_ready_o;
    lsu_pkg::cdb_t [1:0]      cdb_i;
    lsu_pkg::cdb_t            cdb_o;
    logic                     cdb_ready_i;
    logic                     mem_req_valid_o;
    logic                     mem_req_ready_i;
    lsu_pkg::mem_req_t        mem_req_o;
    logic                     mem_resp_valid_i;
    logic                     mem_resp_ready_o;
    lsu_pkg::mem_resp_t       mem_resp_i;

    lsu_pkg::mem_req_t exp_req_q [$];
    lsu_pkg::cdb_t     exp_cdb_q [$];
    lsu_pkg::word_t    resp_q [$];     // vaddr of each accepted request, oldest first
    integer            seed = 99;
    int                errors = 0;
    int                req_count = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    logic              cdb_open;

    lsu_issue_unit u_lsu_issue_unit (
        .clk              (clk),
        .rst_i            (rst_i),
        .flush_i          (flush_i),
        .disp_i           (disp_i),
        .disp_valid_i     (disp_valid_i),
        .disp_ready_o     (disp_ready_o),
        .cdb_i            (cdb_i),
        .cdb_o            (cdb_o),
        .cdb_ready_i      (cdb_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_i       (mem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic lsu_pkg::rob_id_t wake_tag(lsu_pkg::rob_id_t rid);
        return rid ^ 6'h20;  // producer id of the pending base
    endfunction

    function automatic lsu_pkg::word_t row_vaddr(stim_row_t r);
        return {{4{r.imm[27]}}, r.imm} + r.base;
    endfunction

    function automatic lsu_pkg::dispatch_t make_disp(stim_row_t r);
        lsu_pkg::dispatch_t d;
        d.info.mem_write = r.write;
        d.info.msize     = r.size;
        d.info.addr_imm  = r.imm;
        d.info.pc        = 32'h0040_0000 + {r.rid, 2'b00};
        d.info.wreg      = r.rid;
        d.opnd[lsu_pkg::OPND_DATA] = '{1'b1, 6'd0, r.data};
        d.opnd[lsu_pkg::OPND_BASE] = '{!r.pend, wake_tag(r.rid), r.pend ? 32'h0 : r.base};
        return d;
    endfunction

    function automatic lsu_pkg::mem_req_t expect_req(stim_row_t r);
        lsu_pkg::mem_req_t q;
        q.vaddr = row_vaddr(r);
        q.msize = r.size;
        q.write = r.write;
        q.strb  = r.exp_strb;
        case (r.size)
            lsu_pkg::MSIZE_BYTE: q.wdata = r.data << (8 * q.vaddr[1:0]);
            lsu_pkg::MSIZE_HALF: q.wdata = r.data << (16 * q.vaddr[1]);
            default:             q.wdata = r.data;
        endcase
        return q;
    endfunction

    function automatic lsu_pkg::cdb_t expect_cdb(stim_row_t r);
        lsu_pkg::cdb_t c;
        c.valid       = 1'b1;
        c.wid         = r.rid;
        c.target_addr = row_vaddr(r);
        c.wdata       = c.target_addr ^ 32'h5a5a_0000;  // memory model data
        return c;
    endfunction

    task automatic check_req(input lsu_pkg::mem_req_t got, input lsu_pkg::mem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH mem_req_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_cdb(input lsu_pkg::cdb_t got, input lsu_pkg::cdb_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH cdb_o: got %h expected %h", got, exp);
        end
    endtask

    // memory model and result sink, all on the falling edge
    always @(negedge clk) begin
        if (rst_i) begin
            mem_req_ready_i  = 1'b0;
            mem_resp_valid_i = 1'b0;
            cdb_ready_i      = 1'b0;
        end else begin
            // answer first so a request never gets its response in the same cycle
            if (resp_q.size() != 0) begin
                mem_resp_valid_i = 1'b1;
                mem_resp_i.vaddr = resp_q[0];
                mem_resp_i.rdata = resp_q[0] ^ 32'h5a5a_0000;
                if (mem_resp_ready_o) begin
                    void'(resp_q.pop_front());
                end
            end else begin
                mem_resp_valid_i = 1'b0;
            end
            mem_req_ready_i = (($random(seed) & 3) != 0);
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (exp_req_q.size() == 0) begin
                    errors++;
                    $display("memory request %h accepted while none was expected", mem_req_o);
                end else begin
                    check_req(mem_req_o, exp_req_q.pop_front());
                end
                resp_q.push_back(mem_req_o.vaddr);
                req_count++;
            end
            cdb_ready_i = cdb_open;
            if (cdb_o.valid && cdb_ready_i) begin
                if (exp_cdb_q.size() == 0) begin
                    errors++;
                    $display("result %h on cdb_o while none was expected", cdb_o);
                end else begin
                    check_cdb(cdb_o, exp_cdb_q.pop_front());
                end
            end
        end
    end

    // flushed work never returns
    always @(posedge clk) begin
        if (rst_i || flush_i) begin
            exp_req_q.delete();
            exp_cdb_q.delete();
            resp_q.delete();
        end
    end

    task automatic add_expect(input stim_row_t r);
        exp_req_q.push_back(expect_req(r));
        exp_cdb_q.push_back(expect_cdb(r));
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic dispatch_pair(input stim_row_t ra, input stim_row_t rb, input logic two);
        int waited;
        waited = 0;
        while (!disp_ready_o && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!disp_ready_o) begin
            errors++;
            $display("dispatch stalled, disp_ready_o stayed low for 200 cycles");
        end else begin
            disp_i[0]    = make_disp(ra);
            disp_i[1]    = make_disp(rb);
            disp_valid_i = {two, 1'b1};
            add_expect(ra);
            if (two) begin
                add_expect(rb);
            end
            @(negedge clk);
            disp_valid_i = 2'b00;
        end
    endtask

    task automatic broadcast(input int port, input lsu_pkg::rob_id_t tag,
                             input lsu_pkg::word_t value);
        cdb_i[port] = '{1'b1, tag, value, 32'h0};
        @(negedge clk);
        cdb_i[port] = '0;
    endtask

    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        while ((exp_req_q.size() != 0 || exp_cdb_q.size() != 0) && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (exp_req_q.size() != 0 || exp_cdb_q.size() != 0) begin
            errors++;
            $display("%s: requests or results still missing after 1000 cycles", what);
        end
    endtask

    task automatic wait_disp_ready(input logic level);
        int waited;
        waited = 0;
        while (disp_ready_o !== level && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (disp_ready_o !== level) begin
            errors++;
            $display("disp_ready_o never reached %0b within 500 cycles", level);
        end
    endtask

    // full commit FIFO refuses further responses
    task automatic wait_resp_stall();
        int waited;
        waited = 0;
        while (mem_resp_ready_o !== 1'b0 && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (mem_resp_ready_o !== 1'b0) begin
            errors++;
            $display("mem_resp_ready_o never fell while cdb_ready_i was held low");
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        int        mark;
        int        seen;
        stim_row_t ra;
        stim_row_t rb;
        rst_i            = 1'b1;
        flush_i          = 1'b0;
        disp_i           = '0;
        disp_valid_i     = 2'b00;
        cdb_i            = '0;
        cdb_ready_i      = 1'b0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        cdb_open         = 1'b1;
        repeat (4) @(negedge clk);
        rst_i <= 1'b0;

        mark = errors;
        for (int i = 0; i < 11; i += 2) begin
            dispatch_pair(ROWS[i], ROWS[i + 1], i + 1 < 11);
        end
        wait_idle("request format");
        report_test("request format", mark);

        mark = errors;
        seen = req_count;
        dispatch_pair(ROWS[11], ROWS[11], 1'b0);
        repeat (8) @(negedge clk);
        if (req_count != seen) begin
            errors++;
            $display("request issued before its base operand was broadcast");
        end
        broadcast(1, wake_tag(ROWS[11].rid), ROWS[11].base);
        wait_idle("wake-up");
        report_test("wake-up", mark);

        // older one waits for its base, younger one is ready at once
        mark = errors;
        seen = req_count;
        dispatch_pair(ROWS[12], ROWS[13], 1'b1);
        repeat (8) @(negedge clk);
        if (req_count != seen) begin
            errors++;
            $display("younger request issued ahead of a waiting older one");
        end
        broadcast(0, wake_tag(ROWS[12].rid), ROWS[12].base);
        wait_idle("ordering");
        report_test("ordering", mark);

        mark = errors;
        cdb_open <= 1'b0;
        for (int k = 0; k < 18; k += 2) begin
            ra      = ROWS[k % 11];
            rb      = ROWS[(k + 1) % 11];
            ra.rid  = 6'(16 + k);
            rb.rid  = 6'(17 + k);
            ra.base = ra.base + 32'(k * 64);
            rb.base = rb.base + 32'(k * 64 + 64);
            dispatch_pair(ra, rb, 1'b1);
        end
        wait_resp_stall();
        wait_disp_ready(1'b0);
        cdb_open <= 1'b1;
        wait_disp_ready(1'b1);
        wait_idle("back-pressure");
        report_test("back-pressure", mark);

        mark = errors;
        cdb_open <= 1'b0;
        for (int i = 0; i < 6; i += 2) begin
            dispatch_pair(ROWS[i], ROWS[i + 1], 1'b1);
        end
        repeat (12) @(negedge clk);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i  = 1'b0;
        cdb_open <= 1'b1;
        repeat (10) @(negedge clk);  // any result now is a leftover
        dispatch_pair(ROWS[7], ROWS[8], 1'b1);
        dispatch_pair(ROWS[9], ROWS[9], 1'b0);
        wait_idle("flush");
        report_test("flush", mark);

        $display("tests run %0d, tests with errors %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_lsu_issue_unit.u_assertions.failures);
        if (errors == 0 && u_lsu_issue_unit.u_assertions.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/lsu_pkg.sv
rtl/lsu_iq_entry.sv
rtl/lsu_sync_fifo.sv
rtl/lsu_req_format.sv
rtl/lsu_issue_queue.sv
rtl/lsu_issue_unit.sv
verification/lsu_issue_unit_assertions.sv
verification/tb_lsu_issue_unit.sv
